/* csr_unit.f */
+incdir+.
csr_pkg.sv
csr_decode.sv
trap_ctrl.sv
csr_file.sv
csr_unit.sv
tb_csr_unit.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f csr_unit.f --top-module tb_csr_unit \
    -Mdir obj_dir -o sim_csr_unit

./obj_dir/sim_csr_unit | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb_csr_model.svh */
`ifndef TB_CSR_MODEL_SVH
`define TB_CSR_MODEL_SVH

// Expected response of one command and the cycle it is due in
typedef struct packed {
    int unsigned due;
    xword_t      rdata;
    bit          trap;
    bit          redirect;
    xword_t      target;
    priv_t       mode;
} exp_resp_t;

// cycle_i is held at this value for the whole run
localparam logic [63:0] CYCLE_VALUE = 64'h0000_0123_89ab_cdef;

// Model copy of the machine state
priv_t     m_mode;
bit        m_mie;
bit        m_mpie;
priv_t     m_mpp;
bit [2:0]  m_ie;
xword_t    m_mtvec;
xword_t    m_mscratch;
xword_t    m_mepc;
xword_t    m_mcause;
bit        m_msip;
bit        m_meip;
bit        m_mtip;
bit [31:0] lcg_state = 32'd47;

function automatic xword_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

function automatic void model_reset();
    m_mode     = PRIV_M;
    m_mie      = 1'b0;
    m_mpie     = 1'b0;
    m_mpp      = PRIV_M;
    m_ie       = 3'b000;
    m_mtvec    = RESET_VEC;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_msip     = 1'b0;
    m_meip     = 1'b0;
    m_mtip     = 1'b0;
endfunction

function automatic xword_t model_read(input csr_addr_t addr);
    xword_t v;
    v = '0;
    case (addr)
        ADDR_MSTATUS: begin
            v[3]     = m_mie;
            v[7]     = m_mpie;
            v[12:11] = m_mpp;
        end
        // RV32, I and U
        ADDR_MISA:     v = 32'h4010_0100;
        ADDR_MIE:      v = {20'b0, m_ie[2], 3'b0, m_ie[1], 3'b0, m_ie[0], 3'b0};
        ADDR_MTVEC:    v = m_mtvec;
        ADDR_MSCRATCH: v = m_mscratch;
        ADDR_MEPC:     v = m_mepc;
        ADDR_MCAUSE:   v = m_mcause;
        ADDR_MIP:      v = {20'b0, m_meip, 3'b0, m_mtip, 3'b0, m_msip, 3'b0};
        ADDR_MCYCLE:   v = CYCLE_VALUE[31:0];
        ADDR_MCYCLEH:  v = CYCLE_VALUE[63:32];
        default:       v = '0;
    endcase
    return v;
endfunction

function automatic void model_write(input csr_addr_t addr, input xword_t v);
    case (addr)
        ADDR_MSTATUS: begin
            m_mie  = v[3];
            m_mpie = v[7];
            m_mpp  = (v[12:11] == 2'b11) ? PRIV_M : PRIV_U;
        end
        ADDR_MIE:      m_ie       = {v[11], v[7], v[3]};
        ADDR_MTVEC:    m_mtvec    = v;
        ADDR_MSCRATCH: m_mscratch = v;
        ADDR_MEPC:     m_mepc     = v & 32'hffff_fffc;
        ADDR_MCAUSE:   m_mcause   = v;
        default: begin
        end
    endcase
endfunction

// Applies one command to the model and returns what the DUT must answer
function automatic exp_resp_t ref_response(input csr_op_t op, input csr_addr_t addr,
                                           input xword_t wd, input xword_t pc,
                                           input bit ev, input cause_t ec);
    exp_resp_t r;
    bit        is_wr;
    bit        bad;
    bit [2:0]  pend;
    bit        intr;
    bit        take;
    cause_t    cause;
    xword_t    old;
    r     = '0;
    is_wr = (op == OP_RW) || (op == OP_RS) || (op == OP_RC);
    bad   = (is_wr && addr[9:8] > m_mode) || (is_wr && addr[11:10] == 2'b11)
          || (op == OP_MRET && m_mode == PRIV_U);
    pend  = m_ie & {m_meip, m_mtip, m_msip};
    intr  = 1'b0;
    take  = 1'b1;
    cause = '0;
    if (bad) begin
        cause = CAUSE_ILLEGAL_INST;
    end else if (ev) begin
        cause = ec;
    end else if (op == OP_ECALL) begin
        cause = (m_mode == PRIV_U) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
    end else if (pend != 3'b000 && (m_mode == PRIV_U || m_mie)) begin
        intr = 1'b1;
        if (pend[2]) begin
            cause = CAUSE_M_EXT_INTR;
        end else if (pend[0]) begin
            cause = CAUSE_M_SOFT_INTR;
        end else begin
            cause = CAUSE_M_TIMER_INTR;
        end
    end else begin
        take = 1'b0;
    end
    if (take) begin
        r.trap     = 1'b1;
        r.redirect = 1'b1;
        r.target   = m_mtvec & 32'hffff_fffc;
        if (intr && m_mtvec[1:0] == 2'b01) begin
            r.target = r.target + 32'(cause) * 32'd4;
        end
        m_mcause = {intr, 26'b0, cause};
        m_mepc   = pc & 32'hffff_fffc;
        m_mpie   = m_mie;
        m_mie    = 1'b0;
        m_mpp    = m_mode;
        m_mode   = PRIV_M;
    end else if (op == OP_MRET) begin
        r.redirect = 1'b1;
        r.target   = m_mepc;
        m_mode     = m_mpp;
        m_mie      = m_mpie;
        m_mpie     = 1'b1;
        m_mpp      = PRIV_U;
    end else begin
        old     = model_read(addr);
        r.rdata = old;
        if (op == OP_RW) begin
            model_write(addr, wd);
        end else if (op == OP_RS) begin
            model_write(addr, old | wd);
        end else if (op == OP_RC) begin
            model_write(addr, old & ~wd);
        end
    end
    r.mode = m_mode;
    return r;
endfunction

`endif

/* tb_csr_unit.sv */
module tb_csr_unit import csr_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam xword_t RESET_VEC   = 32'h0000_0200;
    localparam int     RAND_ROUNDS = 3;
    // Random rounds of 20 plus the directed sequence
    localparam int     NUM_CMDS    = RAND_ROUNDS * 20 + 46;

    `include "tb_csr_model.svh"

    logic        clk = 1'b0;
    logic        rst_i = 1'b1;
    logic        cmd_valid_i = 1'b0;
    csr_op_t     cmd_op_i = OP_NONE;
    csr_addr_t   cmd_addr_i = '0;
    xword_t      cmd_wdata_i = '0;
    xword_t      cmd_pc_i = '0;
    logic        expt_valid_i = 1'b0;
    cause_t      expt_cause_i = '0;
    logic        msip_i = 1'b0;
    logic        meip_i = 1'b0;
    logic [63:0] mtime_i = 64'd500;
    logic [63:0] mtimecmp_i = 64'd600;
    logic [63:0] cycle_i = CYCLE_VALUE;

    logic        resp_valid_o;
    xword_t      resp_rdata_o;
    logic        resp_trap_o;
    logic        resp_redirect_o;
    xword_t      resp_target_o;
    priv_t       mode_o;

    exp_resp_t   exp_q[$];
    string       name_q[$];
    int unsigned cycle_cnt = 0;
    int          errors = 0;
    csr_addr_t   addr_list [10] = '{ADDR_MSTATUS, ADDR_MISA, ADDR_MIE, ADDR_MTVEC,
                                    ADDR_MSCRATCH, ADDR_MEPC, ADDR_MCAUSE, ADDR_MIP,
                                    ADDR_MCYCLE, ADDR_MCYCLEH};

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    csr_unit #(
        .RESET_VECTOR (RESET_VEC)
    ) dut_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .cmd_valid_i     (cmd_valid_i),
        .cmd_op_i        (cmd_op_i),
        .cmd_addr_i      (cmd_addr_i),
        .cmd_wdata_i     (cmd_wdata_i),
        .cmd_pc_i        (cmd_pc_i),
        .expt_valid_i    (expt_valid_i),
        .expt_cause_i    (expt_cause_i),
        .msip_i          (msip_i),
        .meip_i          (meip_i),
        .mtime_i         (mtime_i),
        .mtimecmp_i      (mtimecmp_i),
        .cycle_i         (cycle_i),
        .resp_valid_o    (resp_valid_o),
        .resp_rdata_o    (resp_rdata_o),
        .resp_trap_o     (resp_trap_o),
        .resp_redirect_o (resp_redirect_o),
        .resp_target_o   (resp_target_o),
        .mode_o          (mode_o)
    );

    task automatic stop_with_failure(input string why);
        errors++;
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_word(input string name, input string field,
                                input xword_t exp_v, input xword_t act_v);
        if (act_v !== exp_v) begin
            stop_with_failure($sformatf("MISMATCH %s %s expected %08h actual %08h",
                                        name, field, exp_v, act_v));
        end
    endtask

    task automatic compare_flag(input string name, input string field,
                                input bit exp_v, input bit act_v);
        if (act_v !== exp_v) begin
            stop_with_failure($sformatf("MISMATCH %s %s expected %0b actual %0b",
                                        name, field, exp_v, act_v));
        end
    endtask

    task automatic compare_mode(input string name, input priv_t exp_v, input priv_t act_v);
        if (act_v !== exp_v) begin
            stop_with_failure($sformatf("MISMATCH %s mode expected %0d actual %0d",
                                        name, exp_v, act_v));
        end
    endtask

    // Drives one command and queues its expected response
    task automatic issue(input string name, input csr_op_t op, input csr_addr_t addr,
                         input xword_t wd, input bit ev = 1'b0, input cause_t ec = '0);
        exp_resp_t e;
        xword_t    pc;
        @(posedge clk);
        pc    = lcg_next();
        e     = ref_response(op, addr, wd, pc, ev, ec);
        e.due = cycle_cnt + 32'd3;
        exp_q.push_back(e);
        name_q.push_back(name);
        cmd_valid_i  <= 1'b1;
        cmd_op_i     <= op;
        cmd_addr_i   <= addr;
        cmd_wdata_i  <= wd;
        cmd_pc_i     <= pc;
        expt_valid_i <= ev;
        expt_cause_i <= ec;
    endtask

    task automatic wait_idle();
        @(posedge clk);
        cmd_valid_i  <= 1'b0;
        expt_valid_i <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // Interrupt lines only move with nothing in flight
    task automatic set_env(input bit sw, input bit ext, input bit tmr);
        wait_idle();
        @(posedge clk);
        msip_i     <= sw;
        meip_i     <= ext;
        mtimecmp_i <= tmr ? 64'd400 : 64'd600;
        m_msip = sw;
        m_meip = ext;
        m_mtip = tmr;
    endtask

    task automatic enter_user(input xword_t ret_pc);
        issue("set_mepc", OP_RW, ADDR_MEPC, ret_pc);
        issue("mpp_user", OP_RC, ADDR_MSTATUS, 32'h0000_1800);
        issue("mret_to_u", OP_MRET, '0, '0);
    endtask

    always @(negedge clk) begin
        exp_resp_t e;
        string     name;
        if (!rst_i && resp_valid_o) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("response arrived with no command in flight");
            end else begin
                e    = exp_q.pop_front();
                name = name_q.pop_front();
                if (e.due != cycle_cnt) begin
                    stop_with_failure($sformatf("%s responded at cycle %0d, due at %0d",
                                                name, cycle_cnt, e.due));
                end else begin
                    compare_word(name, "rdata", e.rdata, resp_rdata_o);
                    compare_flag(name, "trap", e.trap, resp_trap_o);
                    compare_flag(name, "redirect", e.redirect, resp_redirect_o);
                    compare_word(name, "target", e.target, resp_target_o);
                    compare_mode(name, e.mode, mode_o);
                end
            end
        end else if (exp_q.size() != 0 && exp_q[0].due <= cycle_cnt) begin
            stop_with_failure($sformatf("%s got no response by cycle %0d",
                                        name_q[0], cycle_cnt));
        end
    end

    initial begin
        repeat (NUM_CMDS * 3 + 200) @(posedge clk);
        stop_with_failure($sformatf("run did not finish within %0d cycles",
                                    NUM_CMDS * 3 + 200));
    end

    initial begin
        csr_op_t op;
        model_reset();
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;

        // Random writes with a read back in the very next cycle
        for (int r = 0; r < RAND_ROUNDS; r++) begin
            for (int k = 0; k < 10; k++) begin
                op = csr_op_t'(3'(32'd1 + lcg_next() % 32'd3));
                issue("rand_write", op, addr_list[k], lcg_next());
                issue("read_back", OP_RS, addr_list[k], '0);
            end
        end
        issue("unmapped_write", OP_RW, 12'h7c0, lcg_next());
        issue("unmapped_read", OP_RS, 12'h7c0, '0);

        // Access checks in M and U mode
        issue("ro_write", OP_RW, 12'hf11, 32'h1);
        issue("ro_set", OP_RS, 12'hc00, '0);
        issue("ro_mcause", OP_RS, ADDR_MCAUSE, '0);
        issue("mtvec_direct", OP_RW, ADDR_MTVEC, 32'h0000_1000);
        enter_user(32'h0000_2000);
        issue("u_csr_access", OP_RS, ADDR_MSCRATCH, '0);
        enter_user(32'h0000_2100);
        issue("u_mret", OP_MRET, '0, '0);
        issue("illegal_mcause", OP_RS, ADDR_MCAUSE, '0);
        enter_user(32'h0000_2200);
        issue("u_ecall", OP_ECALL, '0, '0);
        issue("ecall_u_mcause", OP_RS, ADDR_MCAUSE, '0);
        issue("m_ecall", OP_ECALL, '0, '0);
        issue("pipe_expt", OP_RS, ADDR_MSCRATCH, '0, 1'b1, 5'd5);
        issue("expt_cause_read", OP_RS, ADDR_MCAUSE, '0);
        // Exceptions ignore the vectored mode
        issue("mtvec_vect", OP_RW, ADDR_MTVEC, 32'h0000_1001);
        issue("vect_ecall", OP_ECALL, '0, '0);
        issue("expt_mcause", OP_RS, ADDR_MCAUSE, '0);
        issue("expt_mepc", OP_RS, ADDR_MEPC, '0);
        issue("mstatus_stack", OP_RW, ADDR_MSTATUS, 32'h0000_1880);
        issue("mret_m", OP_MRET, '0, '0);
        issue("mret_status", OP_RS, ADDR_MSTATUS, '0);

        // Interrupts gated by mstatus.MIE in M mode
        issue("mie_off", OP_RC, ADDR_MSTATUS, 32'h8);
        issue("mie_all", OP_RW, ADDR_MIE, 32'h0000_0888);
        set_env(1'b1, 1'b0, 1'b0);
        issue("gated_read", OP_RS, ADDR_MIP, '0);
        issue("mie_on", OP_RS, ADDR_MSTATUS, 32'h8);
        issue("soft_irq", OP_RS, ADDR_MSCRATCH, '0);
        set_env(1'b1, 1'b1, 1'b1);
        issue("mie_on", OP_RS, ADDR_MSTATUS, 32'h8);
        issue("ext_irq", OP_RS, ADDR_MSCRATCH, '0);
        issue("irq_mcause", OP_RS, ADDR_MCAUSE, '0);
        issue("mtvec_direct", OP_RW, ADDR_MTVEC, 32'h0000_3000);
        set_env(1'b0, 1'b0, 1'b1);
        issue("mie_on", OP_RS, ADDR_MSTATUS, 32'h8);
        issue("timer_irq", OP_RS, ADDR_MSCRATCH, '0);
        issue("mtvec_vect", OP_RW, ADDR_MTVEC, 32'h0000_3001);
        issue("mstatus_user", OP_RW, ADDR_MSTATUS, '0);
        issue("set_mepc", OP_RW, ADDR_MEPC, 32'h0000_4000);
        issue("mret_to_u", OP_MRET, '0, '0);
        // U mode takes the interrupt with MIE clear
        issue("u_timer_irq", OP_RS, 12'h0c0, '0);
        set_env(1'b0, 1'b0, 1'b0);

        wait_idle();
        repeat (4) @(posedge clk);
        if (errors == 0 && exp_q.size() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* csr_unit.sv */
module csr_unit import csr_pkg::*; #(
    parameter xword_t RESET_VECTOR = 32'h0000_0100
) (
    input  logic        clk,
    input  logic        rst_i,

    input  logic        cmd_valid_i,
    input  csr_op_t     cmd_op_i,
    input  csr_addr_t   cmd_addr_i,
    input  xword_t      cmd_wdata_i,
    input  xword_t      cmd_pc_i,
    input  logic        expt_valid_i,
    input  cause_t      expt_cause_i,

    input  logic        msip_i,
    input  logic        meip_i,
    input  logic [63:0] mtime_i,
    input  logic [63:0] mtimecmp_i,
    input  logic [63:0] cycle_i,

    output logic        resp_valid_o,
    output xword_t      resp_rdata_o,
    output logic        resp_trap_o,
    output logic        resp_redirect_o,
    output xword_t      resp_target_o,
    output priv_t       mode_o
);

    // Stage 1 register outputs
    logic      s1_valid;
    csr_op_t   s1_op;
    csr_addr_t s1_addr;
    xword_t    s1_wdata;
    xword_t    s1_pc;
    logic      s1_expt_valid;
    cause_t    s1_expt_cause;
    logic      s1_is_write;

    // Update strobes into the register file
    logic      csr_we;
    logic      trap_take;
    xword_t    trap_cause;
    logic      mret_take;
    priv_t     mode;

    // Machine state seen by the trap logic
    logic       mstatus_mie;
    priv_t      mstatus_mpp;
    logic [2:0] mie_bits;
    logic [2:0] mip_bits;
    xword_t     mtvec;
    xword_t     mepc;

    csr_decode u_decode (
        .clk             (clk),
        .rst_i           (rst_i),
        .cmd_valid_i     (cmd_valid_i),
        .cmd_op_i        (cmd_op_i),
        .cmd_addr_i      (cmd_addr_i),
        .cmd_wdata_i     (cmd_wdata_i),
        .cmd_pc_i        (cmd_pc_i),
        .expt_valid_i    (expt_valid_i),
        .expt_cause_i    (expt_cause_i),
        .s1_valid_o      (s1_valid),
        .s1_op_o         (s1_op),
        .s1_addr_o       (s1_addr),
        .s1_wdata_o      (s1_wdata),
        .s1_pc_o         (s1_pc),
        .s1_expt_valid_o (s1_expt_valid),
        .s1_expt_cause_o (s1_expt_cause),
        .s1_is_write_o   (s1_is_write)
    );

    trap_ctrl u_trap (
        .clk             (clk),
        .rst_i           (rst_i),
        .s1_valid_i      (s1_valid),
        .s1_op_i         (s1_op),
        .s1_addr_i       (s1_addr),
        .s1_is_write_i   (s1_is_write),
        .s1_pc_i         (s1_pc),
        .s1_expt_valid_i (s1_expt_valid),
        .s1_expt_cause_i (s1_expt_cause),
        .mstatus_mie_i   (mstatus_mie),
        .mstatus_mpp_i   (mstatus_mpp),
        .mie_bits_i      (mie_bits),
        .mip_bits_i      (mip_bits),
        .mtvec_i         (mtvec),
        .mepc_i          (mepc),
        .csr_we_o        (csr_we),
        .trap_take_o     (trap_take),
        .trap_cause_o    (trap_cause),
        .mret_take_o     (mret_take),
        .mode_o          (mode),
        .resp_valid_o    (resp_valid_o),
        .resp_trap_o     (resp_trap_o),
        .resp_redirect_o (resp_redirect_o),
        .resp_target_o   (resp_target_o)
    );

    csr_file #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_file (
        .clk           (clk),
        .rst_i         (rst_i),
        .s1_op_i       (s1_op),
        .s1_addr_i     (s1_addr),
        .s1_wdata_i    (s1_wdata),
        .s1_pc_i       (s1_pc),
        .csr_we_i      (csr_we),
        .trap_take_i   (trap_take),
        .trap_cause_i  (trap_cause),
        .mret_take_i   (mret_take),
        .mode_i        (mode),
        .msip_i        (msip_i),
        .meip_i        (meip_i),
        .mtime_i       (mtime_i),
        .mtimecmp_i    (mtimecmp_i),
        .cycle_i       (cycle_i),
        .mstatus_mie_o (mstatus_mie),
        .mstatus_mpp_o (mstatus_mpp),
        .mie_bits_o    (mie_bits),
        .mip_bits_o    (mip_bits),
        .mtvec_o       (mtvec),
        .mepc_o        (mepc),
        .resp_rdata_o  (resp_rdata_o)
    );

    assign mode_o = mode;

endmodule

/* csr_file.sv */
module csr_file import csr_pkg::*; #(
    parameter xword_t RESET_VECTOR = 32'h0000_0100
) (
    input  logic        clk,
    input  logic        rst_i,

    input  csr_op_t     s1_op_i,
    input  csr_addr_t   s1_addr_i,
    input  xword_t      s1_wdata_i,
    input  xword_t      s1_pc_i,

    input  logic        csr_we_i,
    input  logic        trap_take_i,
    input  xword_t      trap_cause_i,
    input  logic        mret_take_i,
    input  priv_t       mode_i,

    input  logic        msip_i,
    input  logic        meip_i,
    input  logic [63:0] mtime_i,
    input  logic [63:0] mtimecmp_i,
    input  logic [63:0] cycle_i,

    output logic        mstatus_mie_o,
    output priv_t       mstatus_mpp_o,
    output logic [2:0]  mie_bits_o,
    output logic [2:0]  mip_bits_o,
    output xword_t      mtvec_o,
    output xword_t      mepc_o,
    output xword_t      resp_rdata_o
);

    logic       mstatus_mie_q;
    logic       mstatus_mpie_q;
    priv_t      mstatus_mpp_q;
    logic [2:0] mie_q;
    xword_t     mtvec_q;
    xword_t     mscratch_q;
    xword_t     mepc_q;
    xword_t     mcause_q;

    logic [2:0] mip_live;
    xword_t     mstatus_rd;
    xword_t     mie_rd;
    xword_t     mip_rd;
    xword_t     rdata;
    xword_t     wdata;
    logic [1:0] mpp_wr;

    // Pending bits come straight from the environment
    assign mip_live = {meip_i, mtime_i >= mtimecmp_i, msip_i};

    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[MSTATUS_MIE_BIT]              = mstatus_mie_q;
        mstatus_rd[MSTATUS_MPIE_BIT]             = mstatus_mpie_q;
        mstatus_rd[MSTATUS_MPP_LSB +: 2]         = mstatus_mpp_q;

        mie_rd = '0;
        mie_rd[IRQ_EXT_BIT]   = mie_q[2];
        mie_rd[IRQ_TIMER_BIT] = mie_q[1];
        mie_rd[IRQ_SOFT_BIT]  = mie_q[0];

        mip_rd = '0;
        mip_rd[IRQ_EXT_BIT]   = mip_live[2];
        mip_rd[IRQ_TIMER_BIT] = mip_live[1];
        mip_rd[IRQ_SOFT_BIT]  = mip_live[0];
    end

    always_comb begin
        case (s1_addr_i)
            ADDR_MSTATUS:  rdata = mstatus_rd;
            ADDR_MISA:     rdata = MISA_VALUE;
            ADDR_MIE:      rdata = mie_rd;
            ADDR_MTVEC:    rdata = mtvec_q;
            ADDR_MSCRATCH: rdata = mscratch_q;
            ADDR_MEPC:     rdata = mepc_q;
            ADDR_MCAUSE:   rdata = mcause_q;
            ADDR_MIP:      rdata = mip_rd;
            ADDR_MCYCLE:   rdata = cycle_i[31:0];
            ADDR_MCYCLEH:  rdata = cycle_i[63:32];
            default:       rdata = '0;
        endcase
    end

    always_comb begin
        case (s1_op_i)
            OP_RW:   wdata = s1_wdata_i;
            OP_RS:   wdata = rdata | s1_wdata_i;
            OP_RC:   wdata = rdata & ~s1_wdata_i;
            default: wdata = rdata;
        endcase
    end

    // MPP is WARL, 01 and 10 fold to U
    assign mpp_wr = (wdata[MSTATUS_MPP_LSB +: 2] == 2'b11) ? 2'b11 : 2'b00;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mstatus_mpp_q  <= PRIV_M;
            mie_q          <= '0;
            mtvec_q        <= RESET_VECTOR;
            mscratch_q     <= '0;
            mepc_q         <= '0;
            mcause_q       <= '0;
        end else if (trap_take_i) begin
            mcause_q       <= trap_cause_i;
            mepc_q         <= {s1_pc_i[XLEN-1:2], 2'b00};
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
            mstatus_mpp_q  <= mode_i;
        end else if (mret_take_i) begin
            mstatus_mie_q  <= mstatus_mpie_q;
            mstatus_mpie_q <= 1'b1;
            mstatus_mpp_q  <= PRIV_U;
        end else if (csr_we_i) begin
            // misa, mip, mcycle and unmapped addresses drop the write
            case (s1_addr_i)
                ADDR_MSTATUS: begin
                    mstatus_mie_q  <= wdata[MSTATUS_MIE_BIT];
                    mstatus_mpie_q <= wdata[MSTATUS_MPIE_BIT];
                    mstatus_mpp_q  <= priv_t'(mpp_wr);
                end
                ADDR_MIE:      mie_q      <= {wdata[IRQ_EXT_BIT], wdata[IRQ_TIMER_BIT],
                                              wdata[IRQ_SOFT_BIT]};
                ADDR_MTVEC:    mtvec_q    <= wdata;
                ADDR_MSCRATCH: mscratch_q <= wdata;
                ADDR_MEPC:     mepc_q     <= {wdata[XLEN-1:2], 2'b00};
                ADDR_MCAUSE:   mcause_q   <= wdata;
                default: begin
                end
            endcase
        end
    end

    // Traps and returns report zero read data
    always_ff @(posedge clk) begin
        resp_rdata_o <= (trap_take_i || mret_take_i) ? '0 : rdata;
    end

    assign mstatus_mie_o = mstatus_mie_q;
    assign mstatus_mpp_o = mstatus_mpp_q;
    assign mie_bits_o    = mie_q;
    assign mip_bits_o    = mip_live;
    assign mtvec_o       = mtvec_q;
    assign mepc_o        = mepc_q;

    a_mepc_aligned: assert property (
        @(posedge clk) disable iff (rst_i)
        mepc_q[1:0] == 2'b00
    );

endmodule

/* trap_ctrl.sv */
module trap_ctrl import csr_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,

    input  logic      s1_valid_i,
    input  csr_op_t   s1_op_i,
    input  csr_addr_t s1_addr_i,
    input  logic      s1_is_write_i,
    input  xword_t    s1_pc_i,
    input  logic      s1_expt_valid_i,
    input  cause_t    s1_expt_cause_i,

    input  logic      mstatus_mie_i,
    input  priv_t     mstatus_mpp_i,
    // Interrupt bit vectors ordered {ext, timer, soft}
    input  logic [2:0] mie_bits_i,
    input  logic [2:0] mip_bits_i,
    input  xword_t    mtvec_i,
    input  xword_t    mepc_i,

    output logic      csr_we_o,
    output logic      trap_take_o,
    output xword_t    trap_cause_o,
    output logic      mret_take_o,
    output priv_t     mode_o,

    output logic      resp_valid_o,
    output logic      resp_trap_o,
    output logic      resp_redirect_o,
    output xword_t    resp_target_o
);

    priv_t      mode_q;
    logic       is_csr_op;
    logic       illegal;
    logic       is_ecall;
    logic [2:0] irq_pend;
    logic       irq_take;
    logic       is_intr;
    cause_t     irq_cause;
    cause_t     cause;
    xword_t     trap_base;
    xword_t     target;

    assign is_csr_op = s1_op_i == OP_RW || s1_op_i == OP_RS || s1_op_i == OP_RC;
    assign is_ecall  = s1_op_i == OP_ECALL;

    // Privilege from address bits 9:8, read-only space at 11:10 = 11
    assign illegal = (is_csr_op && s1_addr_i[9:8] > mode_q)
                   || (s1_is_write_i && s1_addr_i[11:10] == 2'b11)
                   || (s1_op_i == OP_MRET && mode_q == PRIV_U);

    // U mode always takes an enabled interrupt, M mode needs mstatus.MIE
    assign irq_pend = mie_bits_i & mip_bits_i;
    assign irq_take = (|irq_pend) && (mode_q == PRIV_U || mstatus_mie_i);

    always_comb begin
        if (irq_pend[2]) begin
            irq_cause = CAUSE_M_EXT_INTR;
        end else if (irq_pend[0]) begin
            irq_cause = CAUSE_M_SOFT_INTR;
        end else begin
            irq_cause = CAUSE_M_TIMER_INTR;
        end
    end

    // Priority: illegal, pipeline exception, ECALL, interrupt
    always_comb begin
        is_intr = 1'b0;
        if (illegal) begin
            cause = CAUSE_ILLEGAL_INST;
        end else if (s1_expt_valid_i) begin
            cause = s1_expt_cause_i;
        end else if (is_ecall) begin
            cause = (mode_q == PRIV_U) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
        end else begin
            cause   = irq_cause;
            is_intr = 1'b1;
        end
    end

    assign trap_take_o  = s1_valid_i && (illegal || s1_expt_valid_i || is_ecall || irq_take);
    assign trap_cause_o = {is_intr, 26'b0, cause};
    assign mret_take_o  = s1_valid_i && s1_op_i == OP_MRET && !trap_take_o;
    assign csr_we_o     = s1_valid_i && s1_is_write_i && !trap_take_o;

    // Vectored mode offsets interrupts only
    assign trap_base = {mtvec_i[XLEN-1:2], 2'b00};

    always_comb begin
        if (trap_take_o) begin
            if (mtvec_i[1:0] == MTVEC_VECTORED && is_intr) begin
                target = trap_base + {25'b0, cause, 2'b00};
            end else begin
                target = trap_base;
            end
        end else if (mret_take_o) begin
            target = mepc_i;
        end else begin
            target = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mode_q <= PRIV_M;
        end else if (trap_take_o) begin
            mode_q <= PRIV_M;
        end else if (mret_take_o) begin
            mode_q <= mstatus_mpp_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            resp_valid_o    <= 1'b0;
            resp_trap_o     <= 1'b0;
            resp_redirect_o <= 1'b0;
        end else begin
            resp_valid_o    <= s1_valid_i;
            resp_trap_o     <= trap_take_o;
            resp_redirect_o <= trap_take_o || mret_take_o;
        end
    end

    always_ff @(posedge clk) begin
        resp_target_o <= target;
    end

    assign mode_o = mode_q;

    a_trap_mret_excl: assert property (
        @(posedge clk) disable iff (rst_i)
        !(trap_take_o && mret_take_o)
    );

    // csr_file captures the trapping PC in mepc at the same edge
    a_trap_saves_pc: assert property (
        @(posedge clk) disable iff (rst_i)
        trap_take_o |=> mepc_i == {$past(s1_pc_i[XLEN-1:2]), 2'b00}
    );

endmodule

/* csr_decode.sv */
module csr_decode import csr_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,

    input  logic      cmd_valid_i,
    input  csr_op_t   cmd_op_i,
    input  csr_addr_t cmd_addr_i,
    input  xword_t    cmd_wdata_i,
    input  xword_t    cmd_pc_i,
    input  logic      expt_valid_i,
    input  cause_t    expt_cause_i,

    output logic      s1_valid_o,
    output csr_op_t   s1_op_o,
    output csr_addr_t s1_addr_o,
    output xword_t    s1_wdata_o,
    output xword_t    s1_pc_o,
    output logic      s1_expt_valid_o,
    output cause_t    s1_expt_cause_o,
    output logic      s1_is_write_o
);

    // Control bits of stage 1
    always_ff @(posedge clk) begin
        if (rst_i) begin
            s1_valid_o      <= 1'b0;
            s1_expt_valid_o <= 1'b0;
        end else begin
            s1_valid_o      <= cmd_valid_i;
            s1_expt_valid_o <= cmd_valid_i & expt_valid_i;
        end
    end

    // Command payload, only loaded with a valid command
    always_ff @(posedge clk) begin
        if (cmd_valid_i) begin
            s1_op_o         <= cmd_op_i;
            s1_addr_o       <= cmd_addr_i;
            s1_wdata_o      <= cmd_wdata_i;
            s1_pc_o         <= cmd_pc_i;
            s1_expt_cause_o <= expt_cause_i;
        end
    end

    // RW, RS and RC all count as writes
    always_comb begin
        case (s1_op_o)
            OP_RW, OP_RS, OP_RC: s1_is_write_o = 1'b1;
            default:             s1_is_write_o = 1'b0;
        endcase
    end

    // A valid command always carries a real operation
    a_cmd_op_known: assert property (
        @(posedge clk) disable iff (rst_i)
        cmd_valid_i |-> cmd_op_i != OP_NONE
    );

endmodule

/* csr_pkg.sv */
package csr_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xword_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [4:0]      cause_t;

    // Only M and U are implemented
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_t;

    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_RW    = 3'd1,
        OP_RS    = 3'd2,
        OP_RC    = 3'd3,
        OP_ECALL = 3'd4,
        OP_MRET  = 3'd5
    } csr_op_t;

    // Exception causes
    localparam cause_t CAUSE_ILLEGAL_INST = 5'd2;
    localparam cause_t CAUSE_ECALL_U      = 5'd8;
    localparam cause_t CAUSE_ECALL_M      = 5'd11;

    // Interrupt causes, reported with bit 31 of mcause set
    localparam cause_t CAUSE_M_SOFT_INTR  = 5'd3;
    localparam cause_t CAUSE_M_TIMER_INTR = 5'd7;
    localparam cause_t CAUSE_M_EXT_INTR   = 5'd11;

    localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t ADDR_MISA     = 12'h301;
    localparam csr_addr_t ADDR_MIE      = 12'h304;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MIP      = 12'h344;
    localparam csr_addr_t ADDR_MCYCLE   = 12'hb00;
    localparam csr_addr_t ADDR_MCYCLEH  = 12'hb80;

    // MXL = 1, extensions I and U
    localparam xword_t MISA_VALUE = 32'h4010_0100;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // Shared bit positions of mie and mip
    localparam int IRQ_SOFT_BIT  = 3;
    localparam int IRQ_TIMER_BIT = 7;
    localparam int IRQ_EXT_BIT   = 11;

    localparam logic [1:0] MTVEC_VECTORED = 2'b01;

endpackage
